/* compile.f */
+incdir+.
cpu_pkg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
branch_unit.sv
cpu_top.sv
tb_cpu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module tb_cpu -f compile.f \
	--Mdir obj_dir -o tb_cpu_sim; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/tb_cpu_sim > sim.log 2>&1; then
	cat sim.log
	echo "Simulation exited with an error"
	exit 1
fi

cat sim.log
if grep -q "Done: no errors" sim.log; then
	exit 0
fi
exit 1

/* tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Append one word at the next program slot
task automatic emit(input cpu_pkg::instr_t w);
	imem[prog_len] = w;
	prog_len++;
endtask

// Jump over the next two words
task automatic emit_skip(input cpu_pkg::opcode_e op);
	emit(enc_jump(op, cpu_pkg::pc_t'(prog_len + 3)));
endtask

task automatic load_program(input int sel);
	prog_len = 0;
	for (int i = 0; i < (1 << cpu_pkg::PC_W); i++)
		imem[i] = '0;
	case (sel)
		0:
		begin
			// No STORE at all
			test_name = "no_store";
			emit(enc_load(3'd1, 8'h10));
			emit(enc_alu(cpu_pkg::OP_ADD, 3'd2, 3'd1, 3'd1));
			emit('0);
		end
		1:
		begin
			test_name = "arith_fwd";
			emit(enc_load(3'd1, 8'h20));
			emit(enc_load(3'd2, 8'h21));
			// Use right after a load
			emit(enc_alu(cpu_pkg::OP_ADD, 3'd3, 3'd1, 3'd2));
			emit(enc_alu(cpu_pkg::OP_SUB, 3'd4, 3'd3, 3'd1));
			emit(enc_alu(cpu_pkg::OP_SHL, 3'd5, 3'd4, 3'd0));
			emit(enc_store(3'd3, 8'h80));
			emit(enc_store(3'd4, 8'h81));
			emit(enc_alu(cpu_pkg::OP_ADD, 3'd6, 3'd5, 3'd3));
			emit(enc_store(3'd5, 8'h82));
			emit(enc_store(3'd6, 8'h83));
			// Use two instructions after a load
			emit(enc_load(3'd7, 8'h22));
			emit('0);
			emit(enc_alu(cpu_pkg::OP_SUB, 3'd7, 3'd7, 3'd1));
			emit(enc_store(3'd7, 8'h84));
		end
		2:
		begin
			test_name = "bitwise";
			emit(enc_load(3'd1, 8'h30));
			emit(enc_load(3'd2, 8'h31));
			emit(enc_alu(cpu_pkg::OP_AND, 3'd3, 3'd1, 3'd2));
			emit(enc_alu(cpu_pkg::OP_OR, 3'd4, 3'd1, 3'd2));
			emit(enc_alu(cpu_pkg::OP_NOT, 3'd5, 3'd3, 3'd0));
			emit(enc_store(3'd3, 8'h88));
			emit(enc_store(3'd4, 8'h89));
			emit(enc_store(3'd5, 8'h8A));
		end
		3:
		begin
			// Two stores in the flush shadow
			test_name = "jump";
			emit(enc_load(3'd1, 8'h40));
			emit_skip(cpu_pkg::OP_JMP);
			emit(enc_store(3'd1, 8'h90));
			emit(enc_store(3'd1, 8'h91));
			emit(enc_store(3'd1, 8'h92));
			emit(enc_alu(cpu_pkg::OP_ADD, 3'd2, 3'd1, 3'd1));
			emit(enc_store(3'd2, 8'h93));
		end
		default:
		begin
			test_name = "cmp_branch";
			// Equal pair, JEQ taken
			emit(enc_load(3'd1, 8'h50));
			emit(enc_load(3'd2, 8'h50));
			emit(enc_alu(cpu_pkg::OP_CMP, 3'd0, 3'd1, 3'd2));
			emit_skip(cpu_pkg::OP_JEQ);
			emit(enc_store(3'd1, 8'hA0));
			emit(enc_store(3'd2, 8'hA1));
			// Random pair both ways
			emit(enc_load(3'd3, 8'h51));
			emit(enc_load(3'd4, 8'h52));
			emit(enc_alu(cpu_pkg::OP_CMP, 3'd0, 3'd3, 3'd4));
			emit_skip(cpu_pkg::OP_JGT);
			emit(enc_store(3'd3, 8'hA2));
			emit(enc_store(3'd4, 8'hA3));
			emit(enc_alu(cpu_pkg::OP_CMP, 3'd0, 3'd4, 3'd3));
			emit_skip(cpu_pkg::OP_JLT);
			emit(enc_store(3'd3, 8'hA4));
			emit(enc_store(3'd4, 8'hA5));
			// Equal pair, JGT falls through
			emit(enc_alu(cpu_pkg::OP_CMP, 3'd0, 3'd1, 3'd2));
			emit_skip(cpu_pkg::OP_JGT);
			emit(enc_store(3'd1, 8'hA6));
			emit(enc_store(3'd2, 8'hA7));
			emit(enc_store(3'd3, 8'hA8));
		end
	endcase
	// Park on a jump to itself
	emit(enc_jump(cpu_pkg::OP_JMP, cpu_pkg::pc_t'(prog_len)));
endtask

`endif

/* tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

	localparam int NUM_TESTS  = 5;
	localparam int CLK_PERIOD = 20;
	localparam int IDLE_TAIL  = 20;

	logic clk;
	logic reset;

	// DUT memory ports
	cpu_pkg::pc_t       instr_addr;
	cpu_pkg::instr_t    instr_data;
	cpu_pkg::mem_addr_t mem_rd_addr;
	cpu_pkg::data_t     mem_rd_data;
	logic               mem_wr_en;
	cpu_pkg::mem_addr_t mem_wr_addr;
	cpu_pkg::data_t     mem_wr_data;

	// Instruction and data memory plus the model copy
	cpu_pkg::instr_t imem [1 << cpu_pkg::PC_W];
	cpu_pkg::data_t  dmem [1 << cpu_pkg::MEM_ADDR_W];
	cpu_pkg::data_t  ref_mem [1 << cpu_pkg::MEM_ADDR_W];

	// Expected stores in order
	cpu_pkg::mem_addr_t exp_addr [$];
	cpu_pkg::data_t     exp_data [$];

	int    seed;
	int    prog_len;
	string test_name;
	int    errors;
	int    num_checks;
	int    test_seen;
	int    limit_cycles;
	bit    limit_ready;

	cpu_top DUT (
		.clk         (clk),
		.reset       (reset),
		.instr_addr  (instr_addr),
		.instr_data  (instr_data),
		.mem_rd_addr (mem_rd_addr),
		.mem_rd_data (mem_rd_data),
		.mem_wr_en   (mem_wr_en),
		.mem_wr_addr (mem_wr_addr),
		.mem_wr_data (mem_wr_data)
	);

	// Combinational memory reads
	assign instr_data  = imem[instr_addr];
	assign mem_rd_data = dmem[mem_rd_addr];

	// Store strobe taken at the rising edge
	always @(posedge clk)
	begin
		if (mem_wr_en)
			dmem[mem_wr_addr] = mem_wr_data;
	end

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// --------------------------------------------------
	// Assembler helpers
	// --------------------------------------------------
	function automatic cpu_pkg::instr_t enc_alu(input cpu_pkg::opcode_e op,
		input cpu_pkg::reg_addr_t d, input cpu_pkg::reg_addr_t a, input cpu_pkg::reg_addr_t b);
		return {op, d, 1'b0, b, 1'b0, a};
	endfunction

	function automatic cpu_pkg::instr_t enc_load(input cpu_pkg::reg_addr_t d,
		input cpu_pkg::mem_addr_t addr);
		return {cpu_pkg::OP_LOAD, d, addr};
	endfunction

	function automatic cpu_pkg::instr_t enc_store(input cpu_pkg::reg_addr_t a,
		input cpu_pkg::mem_addr_t addr);
		return {cpu_pkg::OP_STORE, addr, a};
	endfunction

	function automatic cpu_pkg::instr_t enc_jump(input cpu_pkg::opcode_e op,
		input cpu_pkg::pc_t target);
		return {op, 1'b0, target};
	endfunction

	`include "tb_programs.svh"

	// --------------------------------------------------
	// Instruction-set level reference model
	// --------------------------------------------------
	function automatic int run_model();
		cpu_pkg::data_t   regs [cpu_pkg::NUM_REGS];
		logic             gt;
		logic             lt;
		logic             eq;
		cpu_pkg::pc_t     pc;
		cpu_pkg::instr_t  w;
		cpu_pkg::opcode_e op;
		cpu_pkg::data_t   a;
		cpu_pkg::data_t   b;
		cpu_pkg::reg_addr_t d;
		cpu_pkg::mem_addr_t st_addr;
		int               steps;
		int               n;
		bit               done;
		for (int i = 0; i < cpu_pkg::NUM_REGS; i++)
			regs[i] = '0;
		gt = 1'b0;
		lt = 1'b0;
		eq = 1'b0;
		pc = cpu_pkg::RESET_PC;
		n = 0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 4000)
		begin
			w  = imem[pc];
			op = cpu_pkg::opcode_e'(w[15:11]);
			a  = regs[w[2:0]];
			b  = regs[w[6:4]];
			d  = w[10:8];
			steps++;
			case (op)
				cpu_pkg::OP_ADD: regs[d] = a + b;
				cpu_pkg::OP_SUB: regs[d] = a - b;
				cpu_pkg::OP_SHL: regs[d] = a << 1;
				cpu_pkg::OP_AND: regs[d] = a & b;
				cpu_pkg::OP_OR:  regs[d] = a | b;
				cpu_pkg::OP_NOT: regs[d] = ~a;
				cpu_pkg::OP_LOAD: regs[d] = ref_mem[w[7:0]];
				cpu_pkg::OP_STORE:
				begin
					st_addr = w[10:3];
					ref_mem[st_addr] = a;
					exp_addr.push_back(st_addr);
					exp_data.push_back(a);
					n++;
				end
				cpu_pkg::OP_CMP:
				begin
					// Unsigned compare
					gt = a > b;
					lt = a < b;
					eq = a == b;
				end
				default:
				begin
				end
			endcase
			if (op == cpu_pkg::OP_JMP && w[9:0] == pc)
				done = 1'b1;
			else if (op == cpu_pkg::OP_JMP || (op == cpu_pkg::OP_JGT && gt)
				|| (op == cpu_pkg::OP_JLT && lt) || (op == cpu_pkg::OP_JEQ && eq))
				pc = w[9:0];
			else
				pc = cpu_pkg::pc_t'(pc + 1);
		end
		return n;
	endfunction

	// Compares two values and reports a mismatch
	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		num_checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	// --------------------------------------------------
	// Store checker sampling at mid-cycle
	// --------------------------------------------------
	always @(negedge clk)
	begin
		if (mem_wr_en === 1'b1)
		begin
			if (reset)
			begin
				errors++;
				$display("Store strobe seen while reset is high");
			end
			else if (exp_addr.size() == 0)
			begin
				errors++;
				$display("Unexpected extra store to address 0x%0h", mem_wr_addr);
			end
			else
			begin
				check_value("mem_wr_addr", 32'(exp_addr.pop_front()), 32'(mem_wr_addr));
				check_value("mem_wr_data", 32'(exp_data.pop_front()), 32'(mem_wr_data));
				test_seen++;
			end
		end
	end

	// Watchdog from summed program lengths
	initial
	begin
		wait (limit_ready);
		#(limit_cycles * CLK_PERIOD);
		$display("Timeout: tests did not finish within %0d cycles", limit_cycles);
		$display("Done: errors found");
		$finish;
	end

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial
	begin
		int exp_count;
		int errs_before;
		reset        = 1'b1;
		seed         = 71926;
		errors       = 0;
		num_checks   = 0;
		test_seen    = 0;
		limit_cycles = 0;
		limit_ready  = 1'b0;
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			load_program(t);
			limit_cycles += prog_len + 40;
		end
		limit_ready = 1'b1;

		for (int t = 0; t < NUM_TESTS; t++)
		begin
			reset = 1'b1;
			load_program(t);
			// Random data memory that the model also starts from
			for (int i = 0; i < (1 << cpu_pkg::MEM_ADDR_W); i++)
			begin
				dmem[i]    = cpu_pkg::data_t'($random(seed));
				ref_mem[i] = dmem[i];
			end
			exp_addr.delete();
			exp_data.delete();
			exp_count   = run_model();
			test_seen   = 0;
			errs_before = errors;
			repeat (5) @(negedge clk);
			reset = 1'b0;
			while (test_seen < exp_count)
				@(negedge clk);
			repeat (IDLE_TAIL) @(negedge clk);
			$display("Test %0d %s: %0d of %0d stores, %0d errors", t, test_name,
				test_seen, exp_count, errors - errs_before);
		end

		$display("Tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, num_checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
	input  wire logic            clk,
	input  wire logic            reset,
	// Instruction memory, combinational read
	output cpu_pkg::pc_t         instr_addr,
	input  wire cpu_pkg::instr_t instr_data,
	// Data memory
	output cpu_pkg::mem_addr_t   mem_rd_addr,
	input  wire cpu_pkg::data_t  mem_rd_data,
	output logic                 mem_wr_en,
	output cpu_pkg::mem_addr_t   mem_wr_addr,
	output cpu_pkg::data_t       mem_wr_data
);

	// --------------------------------------------------
	// Stage wiring
	// --------------------------------------------------
	logic                     redirect;
	logic                     flush;
	cpu_pkg::pc_t             br_target;
	cpu_pkg::instr_t          if_instr;
	logic                     if_valid;
	cpu_pkg::reg_addr_t       rs1_addr;
	cpu_pkg::reg_addr_t       rs2_addr;
	cpu_pkg::data_t           rs1_data;
	cpu_pkg::data_t           rs2_data;
	cpu_pkg::ex_ctrl_t        ex_ctrl;
	cpu_pkg::data_t           ex_op1;
	cpu_pkg::data_t           ex_op2;
	logic [cpu_pkg::DATA_W:0] alu_result;
	cpu_pkg::wb_bus_t         wb;

	// Fetch
	fetch_stage u_fetch (
		.clk      (clk),
		.reset    (reset),
		.redirect (redirect),
		.target   (br_target),
		.pc       (instr_addr),
		.instr_in (instr_data),
		.if_instr (if_instr),
		.if_valid (if_valid)
	);

	// Decode and operand read
	decode_stage u_decode (
		.clk      (clk),
		.reset    (reset),
		.if_instr (if_instr),
		.if_valid (if_valid),
		.flush    (flush),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb       (wb),
		.ex_ctrl  (ex_ctrl),
		.ex_op1   (ex_op1),
		.ex_op2   (ex_op2)
	);

	register_file u_regs (
		.clk      (clk),
		.reset    (reset),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb       (wb)
	);

	// Execute and write-back
	execute_stage u_execute (
		.clk         (clk),
		.reset       (reset),
		.ex_ctrl     (ex_ctrl),
		.ex_op1      (ex_op1),
		.ex_op2      (ex_op2),
		.alu_result  (alu_result),
		.mem_rd_addr (mem_rd_addr),
		.mem_rd_data (mem_rd_data),
		.mem_wr_en   (mem_wr_en),
		.mem_wr_addr (mem_wr_addr),
		.mem_wr_data (mem_wr_data),
		.wb          (wb)
	);

	branch_unit u_branch (
		.clk        (clk),
		.reset      (reset),
		.ex_ctrl    (ex_ctrl),
		.alu_result (alu_result),
		.redirect   (redirect),
		.target     (br_target),
		.flush      (flush)
	);

endmodule

`default_nettype wire

/* branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire cpu_pkg::ex_ctrl_t   ex_ctrl,
	input  wire [cpu_pkg::DATA_W:0]  alu_result,
	output logic                     redirect,
	output cpu_pkg::pc_t             target,
	output logic                     flush
);

	logic gt_flag;
	logic lt_flag;
	logic eq_flag;
	logic diff_zero;
	logic borrow;
	logic taken;

	// --------------------------------------------------
	// Compare flags
	// --------------------------------------------------
	// a + ~b + 1 carries out unless a < b
	assign diff_zero = (alu_result[cpu_pkg::DATA_W-1:0] == '0);
	assign borrow    = !alu_result[cpu_pkg::DATA_W];

	// Written at the end of the CMP execute cycle
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			gt_flag <= 1'b0;
			lt_flag <= 1'b0;
			eq_flag <= 1'b0;
		end
		else if (ex_ctrl.valid && ex_ctrl.is_cmp)
		begin
			gt_flag <= !borrow && !diff_zero;
			lt_flag <= borrow;
			eq_flag <= diff_zero;
		end
	end

	// --------------------------------------------------
	// Branch decision
	// --------------------------------------------------
	// Held flags, so a jump right after CMP sees its result
	assign taken = ex_ctrl.valid && (ex_ctrl.jump_uncond
		|| (ex_ctrl.jump_gt && gt_flag)
		|| (ex_ctrl.jump_lt && lt_flag)
		|| (ex_ctrl.jump_eq && eq_flag));

	assign redirect = taken;
	assign flush    = taken;
	assign target   = ex_ctrl.target;

	// Exactly one relation holds after any compare
	a_flags_onehot: assert property (@(posedge clk) disable iff (reset)
		(ex_ctrl.valid && ex_ctrl.is_cmp) |=> $onehot({gt_flag, lt_flag, eq_flag}));

endmodule

`default_nettype wire

/* execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire cpu_pkg::ex_ctrl_t  ex_ctrl,
	input  wire cpu_pkg::data_t     ex_op1,
	input  wire cpu_pkg::data_t     ex_op2,
	// Sum with adder carry on top
	output logic [cpu_pkg::DATA_W:0] alu_result,
	output cpu_pkg::mem_addr_t      mem_rd_addr,
	input  wire cpu_pkg::data_t     mem_rd_data,
	output logic                    mem_wr_en,
	output cpu_pkg::mem_addr_t      mem_wr_addr,
	output cpu_pkg::data_t          mem_wr_data,
	output cpu_pkg::wb_bus_t        wb
);

	// Execute/write-back register contents
	typedef struct packed {
		logic               valid;
		logic               reg_write;
		logic               is_load;
		logic               is_store;
		cpu_pkg::reg_addr_t dest_addr;
		cpu_pkg::mem_addr_t mem_addr;
		cpu_pkg::data_t     result;
	} ex_wb_t;

	cpu_pkg::data_t          op1;
	cpu_pkg::data_t          op2;
	cpu_pkg::data_t          alu_b;
	logic [cpu_pkg::DATA_W:0] sum;
	cpu_pkg::data_t          result;
	ex_wb_t                  exwb_next;
	ex_wb_t                  exwb;

	// --------------------------------------------------
	// Operand forwarding from write-back
	// --------------------------------------------------
	// Covers the instruction directly ahead, loads included
	assign op1 = (wb.reg_write && wb.dest_addr == ex_ctrl.op1_addr) ? wb.data : ex_op1;
	assign op2 = (wb.reg_write && wb.dest_addr == ex_ctrl.op2_addr) ? wb.data : ex_op2;

	// Operand 2 prep
	always_comb
	begin
		if (ex_ctrl.op2_zero)
			alu_b = '0;
		else if (ex_ctrl.op2_invert)
			alu_b = ~op2;
		else
			alu_b = op2;
	end

	// --------------------------------------------------
	// ALU
	// --------------------------------------------------
	// 9-bit adder, carry-in set for SUB and CMP
	assign sum = {1'b0, op1} + {1'b0, alu_b}
		+ {{cpu_pkg::DATA_W{1'b0}}, ex_ctrl.carry_in};

	always_comb
	begin
		case (ex_ctrl.alu_op)
			cpu_pkg::ALU_ADD:
				result = sum[cpu_pkg::DATA_W-1:0];
			cpu_pkg::ALU_SHL:
				// Zero enters at bit 0
				result = {op1[cpu_pkg::DATA_W-2:0], 1'b0};
			cpu_pkg::ALU_AND:
				result = op1 & alu_b;
			cpu_pkg::ALU_OR:
				result = op1 | alu_b;
			cpu_pkg::ALU_NOT:
				result = ~op1;
			default:
				result = sum[cpu_pkg::DATA_W-1:0];
		endcase
	end

	// Branch unit only looks at this for CMP
	assign alu_result = sum;

	// --------------------------------------------------
	// Execute/write-back register
	// --------------------------------------------------
	always_comb
	begin
		exwb_next.valid     = ex_ctrl.valid;
		exwb_next.reg_write = ex_ctrl.reg_write;
		exwb_next.is_load   = ex_ctrl.is_load;
		exwb_next.is_store  = ex_ctrl.is_store;
		exwb_next.dest_addr = ex_ctrl.dest_addr;
		exwb_next.mem_addr  = ex_ctrl.mem_addr;
		exwb_next.result    = result;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			exwb.valid <= 1'b0;
		else
			exwb <= exwb_next;
	end

	// --------------------------------------------------
	// Write-back
	// --------------------------------------------------
	// Load address goes out combinationally, data returns this cycle
	assign mem_rd_addr = exwb.mem_addr;

	assign wb.reg_write = exwb.valid && exwb.reg_write;
	assign wb.dest_addr = exwb.dest_addr;
	assign wb.data      = exwb.is_load ? mem_rd_data : exwb.result;

	// One-cycle store strobe, memory takes it at the next edge
	assign mem_wr_en   = exwb.valid && exwb.is_store;
	assign mem_wr_addr = exwb.mem_addr;
	assign mem_wr_data = exwb.result;

	// Store and register write never share a slot
	a_wr_excl: assert property (@(posedge clk) disable iff (reset)
		!(mem_wr_en && wb.reg_write));

endmodule

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire cpu_pkg::instr_t    if_instr,
	input  wire logic               if_valid,
	input  wire logic               flush,
	output cpu_pkg::reg_addr_t      rs1_addr,
	output cpu_pkg::reg_addr_t      rs2_addr,
	input  wire cpu_pkg::data_t     rs1_data,
	input  wire cpu_pkg::data_t     rs2_data,
	input  wire cpu_pkg::wb_bus_t   wb,
	output cpu_pkg::ex_ctrl_t       ex_ctrl,
	output cpu_pkg::data_t          ex_op1,
	output cpu_pkg::data_t          ex_op2
);

	cpu_pkg::opcode_e  opcode;
	cpu_pkg::ex_ctrl_t dec;
	cpu_pkg::data_t    op1_fwd;
	cpu_pkg::data_t    op2_fwd;

	// --------------------------------------------------
	// Field slicing
	// --------------------------------------------------
	assign opcode   = cpu_pkg::opcode_e'(if_instr[cpu_pkg::OPCODE_LSB +: cpu_pkg::OPCODE_W]);
	assign rs1_addr = if_instr[cpu_pkg::OP1_LSB +: cpu_pkg::REG_ADDR_W];
	assign rs2_addr = if_instr[cpu_pkg::OP2_LSB +: cpu_pkg::REG_ADDR_W];

	// --------------------------------------------------
	// Opcode to control
	// --------------------------------------------------
	always_comb
	begin
		// Defaults give a NOP with no writes
		dec           = '0;
		dec.valid     = if_valid;
		dec.alu_op    = cpu_pkg::ALU_ADD;
		dec.op1_addr  = rs1_addr;
		dec.op2_addr  = rs2_addr;
		dec.dest_addr = if_instr[cpu_pkg::DEST_LSB +: cpu_pkg::REG_ADDR_W];
		dec.target    = if_instr[cpu_pkg::TARGET_LSB +: cpu_pkg::PC_W];
		case (opcode)
			cpu_pkg::OP_ADD:
				dec.reg_write = 1'b1;
			cpu_pkg::OP_SUB:
			begin
				// a + ~b + 1
				dec.op2_invert = 1'b1;
				dec.carry_in   = 1'b1;
				dec.reg_write  = 1'b1;
			end
			cpu_pkg::OP_SHL:
			begin
				dec.alu_op    = cpu_pkg::ALU_SHL;
				dec.reg_write = 1'b1;
			end
			cpu_pkg::OP_JMP:
				dec.jump_uncond = 1'b1;
			cpu_pkg::OP_LOAD:
			begin
				dec.is_load   = 1'b1;
				dec.reg_write = 1'b1;
				dec.mem_addr  = if_instr[cpu_pkg::LD_ADDR_LSB +: cpu_pkg::MEM_ADDR_W];
			end
			cpu_pkg::OP_STORE:
			begin
				// Operand 1 passes the adder unchanged
				dec.is_store = 1'b1;
				dec.op2_zero = 1'b1;
				dec.mem_addr = if_instr[cpu_pkg::ST_ADDR_LSB +: cpu_pkg::MEM_ADDR_W];
			end
			cpu_pkg::OP_AND:
			begin
				dec.alu_op    = cpu_pkg::ALU_AND;
				dec.reg_write = 1'b1;
			end
			cpu_pkg::OP_OR:
			begin
				dec.alu_op    = cpu_pkg::ALU_OR;
				dec.reg_write = 1'b1;
			end
			cpu_pkg::OP_NOT:
			begin
				dec.alu_op    = cpu_pkg::ALU_NOT;
				dec.reg_write = 1'b1;
			end
			cpu_pkg::OP_CMP:
			begin
				// Subtract for flags, no register write
				dec.op2_invert = 1'b1;
				dec.carry_in   = 1'b1;
				dec.is_cmp     = 1'b1;
			end
			cpu_pkg::OP_JGT:
				dec.jump_gt = 1'b1;
			cpu_pkg::OP_JLT:
				dec.jump_lt = 1'b1;
			cpu_pkg::OP_JEQ:
				dec.jump_eq = 1'b1;
			default:
			begin
				// NOP and unused opcodes
			end
		endcase
	end

	// Write-back result in flight bypasses the register file
	assign op1_fwd = (wb.reg_write && wb.dest_addr == rs1_addr) ? wb.data : rs1_data;
	assign op2_fwd = (wb.reg_write && wb.dest_addr == rs2_addr) ? wb.data : rs2_data;

	// --------------------------------------------------
	// Decode/execute register
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			ex_ctrl <= '0;
		else
		begin
			ex_ctrl       <= dec;
			// Taken branch in execute kills this slot
			ex_ctrl.valid <= dec.valid && !flush;
		end
	end

	// Operand values
	always_ff @(posedge clk)
	begin
		ex_op1 <= op1_fwd;
		ex_op2 <= op2_fwd;
	end

	// Jump kinds exclusive in the execute slot
	a_one_jump: assert property (@(posedge clk) disable iff (reset)
		$onehot0({ex_ctrl.jump_uncond, ex_ctrl.jump_gt, ex_ctrl.jump_lt, ex_ctrl.jump_eq}));

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire cpu_pkg::reg_addr_t rs1_addr,
	input  wire cpu_pkg::reg_addr_t rs2_addr,
	output cpu_pkg::data_t          rs1_data,
	output cpu_pkg::data_t          rs2_data,
	input  wire cpu_pkg::wb_bus_t   wb
);

	cpu_pkg::data_t regs [cpu_pkg::NUM_REGS];

	// Single write port, fed from write-back
	always_ff @(posedge clk)
	begin
		if (reset)
			regs <= '{default: '0};
		else if (wb.reg_write)
			regs[wb.dest_addr] <= wb.data;
	end

	// Combinational reads, same-cycle writes come in by forwarding
	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

/* fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
	input  wire logic           clk,
	input  wire logic           reset,
	input  wire logic           redirect,
	input  wire cpu_pkg::pc_t   target,
	output cpu_pkg::pc_t        pc,
	input  wire cpu_pkg::instr_t instr_in,
	output cpu_pkg::instr_t     if_instr,
	output logic                if_valid
);

	// --------------------------------------------------
	// Program counter and fetch valid
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc       <= cpu_pkg::RESET_PC;
			if_valid <= 1'b0;
		end
		else if (redirect)
		begin
			// Taken branch, word at the old pc is dropped
			pc       <= target;
			if_valid <= 1'b0;
		end
		else
		begin
			pc       <= cpu_pkg::pc_t'(pc + 1'b1);
			if_valid <= 1'b1;
		end
	end

	// Fetch register, qualified by if_valid
	always_ff @(posedge clk)
	begin
		if_instr <= instr_in;
	end

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	// --------------------------------------------------
	// Widths and counts
	// --------------------------------------------------
	localparam int DATA_W     = 8;
	localparam int REG_ADDR_W = 3;
	localparam int MEM_ADDR_W = 8;
	localparam int PC_W       = 10;
	localparam int INSTR_W    = 16;
	localparam int OPCODE_W   = 5;
	localparam int NUM_REGS   = 8;

	typedef logic [DATA_W-1:0]     data_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
	typedef logic [PC_W-1:0]       pc_t;
	typedef logic [INSTR_W-1:0]    instr_t;

	// First fetch address after reset
	localparam pc_t RESET_PC = '0;

	// --------------------------------------------------
	// Instruction fields, given by their low bit
	// --------------------------------------------------
	localparam int OPCODE_LSB  = 11;
	localparam int DEST_LSB    = 8;
	localparam int OP2_LSB     = 4;
	localparam int OP1_LSB     = 0;
	localparam int LD_ADDR_LSB = 0;
	// Store address sits above the source register field
	localparam int ST_ADDR_LSB = 3;
	localparam int TARGET_LSB  = 0;

	// Opcodes; every code not listed runs as a NOP
	typedef enum logic [OPCODE_W-1:0] {
		OP_NOP   = 5'h00,
		OP_ADD   = 5'h01,
		OP_SUB   = 5'h02,
		OP_SHL   = 5'h06,
		OP_JMP   = 5'h07,
		OP_LOAD  = 5'h08,
		OP_STORE = 5'h09,
		OP_AND   = 5'h0A,
		OP_OR    = 5'h0B,
		OP_NOT   = 5'h0C,
		OP_CMP   = 5'h0D,
		OP_JGT   = 5'h0E,
		OP_JLT   = 5'h0F,
		OP_JEQ   = 5'h10
	} opcode_e;

	// ALU result select
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SHL = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_NOT = 3'd4
	} alu_op_e;

	// --------------------------------------------------
	// Stage buses
	// --------------------------------------------------
	// Decode/execute control word
	typedef struct packed {
		logic      valid;
		alu_op_e   alu_op;
		logic      op2_invert;
		logic      carry_in;
		logic      op2_zero;
		logic      is_load;
		logic      is_store;
		logic      is_cmp;
		logic      reg_write;
		logic      jump_uncond;
		logic      jump_gt;
		logic      jump_lt;
		logic      jump_eq;
		reg_addr_t op1_addr;
		reg_addr_t op2_addr;
		reg_addr_t dest_addr;
		mem_addr_t mem_addr;
		pc_t       target;
	} ex_ctrl_t;

	// Register write of this cycle, also the forwarding source
	typedef struct packed {
		logic      reg_write;
		reg_addr_t dest_addr;
		data_t     data;
	} wb_bus_t;

endpackage

`default_nettype wire
